//--- include/maze_defines.svh
`ifndef MAZE_DEFINES_SVH
`define MAZE_DEFINES_SVH

// Grid geometry
`define GRID_W          64
`define GRID_H          32
`define CELL_X_W        6
`define CELL_Y_W        5

// Player position is fixed point, cell index in the integer part
`define FRAC_W          8
`define POS_X_W         14
`define POS_Y_W         13
`define ANGLE_W         8
`define START_POS       384
`define MOVE_STEP       32
`define TURN_STEP       8

// Interior pillars
`define PILLAR_PERIOD   8
`define PILLAR_PHASE    4

// Pixel output, RGB 6:6:6
`define VGA_X_W         8
`define VGA_Y_W         7
`define COLOUR_W        18
`define COLOUR_FLOOR    18'h08208
`define COLOUR_WALL     18'h3ffff
`define COLOUR_PLAYER   18'h3f000

`endif

//--- logic/maze_pkg.sv
package maze_pkg;

    typedef enum logic [2:0] {
        CELL_EMPTY = 3'd0,
        CELL_WALL  = 3'd1
    } cell_t;

    typedef enum logic [1:0] {
        OWNER_NONE,
        OWNER_LOADER,
        OWNER_RENDERER,
        OWNER_UPDATER
    } grid_owner_t;

    typedef enum logic [2:0] {
        S_LOAD,
        S_LOAD_WAIT,
        S_RENDER,
        S_RENDER_WAIT,
        S_UPDATE,
        S_UPDATE_WAIT
    } seq_state_t;

endpackage

//--- logic/grid_port_if.sv
`timescale 1ns/1ns
`include "maze_defines.svh"

interface grid_port_if;
    logic [`CELL_X_W-1:0] cell_x;
    logic [`CELL_Y_W-1:0] cell_y;
    logic                 write;
    logic [2:0]           write_data;
    logic [2:0]           read_data;

    modport client (
        output cell_x,
        output cell_y,
        output write,
        output write_data,
        input  read_data
    );

    modport memory (
        input  cell_x,
        input  cell_y,
        input  write,
        input  write_data,
        output read_data
    );
endinterface

//--- logic/hex_decoder.sv
`timescale 1ns/1ns

module hex_decoder (
    input  logic [3:0] nibble,
    output logic [6:0] segments
);
    // Active low, bit 0 is segment a
    always_comb begin
        case (nibble)
            4'h0: segments = 7'b1000000;
            4'h1: segments = 7'b1111001;
            4'h2: segments = 7'b0100100;
            4'h3: segments = 7'b0110000;
            4'h4: segments = 7'b0011001;
            4'h5: segments = 7'b0010010;
            4'h6: segments = 7'b0000010;
            4'h7: segments = 7'b1111000;
            4'h8: segments = 7'b0000000;
            4'h9: segments = 7'b0010000;
            4'ha: segments = 7'b0001000;
            4'hb: segments = 7'b0000011;
            4'hc: segments = 7'b1000110;
            4'hd: segments = 7'b0100001;
            4'he: segments = 7'b0000110;
            default: segments = 7'b0001110;
        endcase
    end
endmodule

//--- logic/game_sequencer.sv
`timescale 1ns/1ns

module game_sequencer
    import maze_pkg::*;
(
    input  logic        clock,
    input  logic        reset,
    input  logic        load_done,
    input  logic        render_done,
    input  logic        update_done,
    output logic        load_start,
    output logic        render_start,
    output logic        update_start,
    output grid_owner_t grid_owner
);
    seq_state_t state;

    always_ff @(posedge clock) begin
        if (reset) begin
            state        <= S_LOAD;
            load_start   <= 1'b0;
            render_start <= 1'b0;
            update_start <= 1'b0;
        end else begin
            load_start   <= 1'b0;
            render_start <= 1'b0;
            update_start <= 1'b0;
            case (state)
                S_LOAD: begin
                    load_start <= 1'b1;
                    state      <= S_LOAD_WAIT;
                end
                S_LOAD_WAIT: begin
                    if (load_done) begin
                        state <= S_RENDER;
                    end
                end
                S_RENDER: begin
                    render_start <= 1'b1;
                    state        <= S_RENDER_WAIT;
                end
                S_RENDER_WAIT: begin
                    if (render_done) begin
                        state <= S_UPDATE;
                    end
                end
                S_UPDATE: begin
                    update_start <= 1'b1;
                    state        <= S_UPDATE_WAIT;
                end
                S_UPDATE_WAIT: begin
                    // Loop forever on the same maze
                    if (update_done) begin
                        state <= S_RENDER;
                    end
                end
                default: state <= S_LOAD;
            endcase
        end
    end

    always_comb begin
        case (state)
            S_LOAD_WAIT:   grid_owner = OWNER_LOADER;
            S_RENDER_WAIT: grid_owner = OWNER_RENDERER;
            S_UPDATE_WAIT: grid_owner = OWNER_UPDATER;
            default:       grid_owner = OWNER_NONE;
        endcase
    end
endmodule

//--- logic/grid_memory.sv
`timescale 1ns/1ns
`include "maze_defines.svh"

module grid_memory
    import maze_pkg::*;
(
    input  logic        clock,
    input  grid_owner_t grid_owner,
    grid_port_if.memory loader,
    grid_port_if.memory renderer,
    grid_port_if.memory updater
);
    localparam int ADDR_W = `CELL_Y_W + `CELL_X_W;

    cell_t             cells [`GRID_W * `GRID_H];
    logic [ADDR_W-1:0] addr;
    logic              write;
    logic [2:0]        write_data;
    cell_t             read_q;

    always_comb begin
        addr       = '0;
        write      = 1'b0;
        write_data = '0;
        case (grid_owner)
            OWNER_LOADER: begin
                addr       = {loader.cell_y, loader.cell_x};
                write      = loader.write;
                write_data = loader.write_data;
            end
            OWNER_RENDERER: begin
                addr       = {renderer.cell_y, renderer.cell_x};
                write      = renderer.write;
                write_data = renderer.write_data;
            end
            OWNER_UPDATER: begin
                addr       = {updater.cell_y, updater.cell_x};
                write      = updater.write;
                write_data = updater.write_data;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clock) begin
        if (write) begin
            cells[addr] <= cell_t'(write_data);
        end
        read_q <= cells[addr];
    end

    // One read register shared by every client
    assign loader.read_data   = read_q;
    assign renderer.read_data = read_q;
    assign updater.read_data  = read_q;
endmodule

//--- logic/level_loader.sv
`timescale 1ns/1ns
`include "maze_defines.svh"

module level_loader
    import maze_pkg::*;
(
    input  logic        clock,
    input  logic        reset,
    input  logic        start,
    output logic        done,
    grid_port_if.client grid
);
    logic                             active;
    logic [`CELL_Y_W+`CELL_X_W-1:0]   cell_idx;
    logic [`CELL_X_W-1:0]             x;
    logic [`CELL_Y_W-1:0]             y;
    logic                             border;
    logic                             pillar;

    assign x = cell_idx[`CELL_X_W-1:0];
    assign y = cell_idx[`CELL_X_W +: `CELL_Y_W];

    assign border = (x == 0) || (x == `GRID_W - 1) || (y == 0) || (y == `GRID_H - 1);
    assign pillar = ((x % `PILLAR_PERIOD) == `PILLAR_PHASE)
                 && ((y % `PILLAR_PERIOD) == `PILLAR_PHASE);

    assign grid.cell_x     = x;
    assign grid.cell_y     = y;
    assign grid.write      = active;
    assign grid.write_data = (border || pillar) ? CELL_WALL : CELL_EMPTY;

    always_ff @(posedge clock) begin
        if (reset) begin
            active   <= 1'b0;
            cell_idx <= '0;
            done     <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start) begin
                active   <= 1'b1;
                cell_idx <= '0;
            end else if (active) begin
                cell_idx <= cell_idx + 1'b1;
                if (cell_idx == '1) begin
                    active <= 1'b0;
                    done   <= 1'b1;
                end
            end
        end
    end
endmodule

//--- logic/grid_renderer.sv
`timescale 1ns/1ns
`include "maze_defines.svh"

module grid_renderer
    import maze_pkg::*;
(
    input  logic                 clock,
    input  logic                 reset,
    input  logic                 start,
    output logic                 done,
    grid_port_if.client          grid,
    input  logic [`CELL_X_W-1:0] player_cell_x,
    input  logic [`CELL_Y_W-1:0] player_cell_y,
    input  logic                 vga_ready,
    output logic [`VGA_X_W-1:0]  vga_x,
    output logic [`VGA_Y_W-1:0]  vga_y,
    output logic [`COLOUR_W-1:0] vga_colour,
    output logic                 vga_write
);
    localparam int IDX_W = `CELL_Y_W + `CELL_X_W;

    logic             active;
    logic             cells_issued;
    logic             marker_issued;
    logic [IDX_W-1:0] scan_idx;
    logic             rd_valid;
    logic             rd_marker;
    logic [IDX_W-1:0] rd_idx;
    logic             out_marker;
    logic             advance;
    logic             issue_cell;
    logic             issue_marker;

    // Output register is free or draining this cycle
    assign advance      = !vga_write || vga_ready;
    assign issue_cell   = active && !cells_issued && advance;
    assign issue_marker = active && cells_issued && !marker_issued && advance;

    // On a stall, re-read the pending cell so read_data stays valid
    assign grid.cell_x     = advance ? scan_idx[`CELL_X_W-1:0] : rd_idx[`CELL_X_W-1:0];
    assign grid.cell_y     = advance ? scan_idx[`CELL_X_W +: `CELL_Y_W]
                                     : rd_idx[`CELL_X_W +: `CELL_Y_W];
    assign grid.write      = 1'b0;
    assign grid.write_data = '0;

    always_ff @(posedge clock) begin
        if (reset) begin
            active        <= 1'b0;
            cells_issued  <= 1'b0;
            marker_issued <= 1'b0;
            scan_idx      <= '0;
            rd_valid      <= 1'b0;
            rd_marker     <= 1'b0;
            out_marker    <= 1'b0;
            vga_write     <= 1'b0;
            done          <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start) begin
                active        <= 1'b1;
                cells_issued  <= 1'b0;
                marker_issued <= 1'b0;
                scan_idx      <= '0;
            end
            if (issue_cell) begin
                scan_idx <= scan_idx + 1'b1;
                if (scan_idx == '1) begin
                    cells_issued <= 1'b1;
                end
            end
            if (issue_marker) begin
                marker_issued <= 1'b1;
            end
            if (advance) begin
                rd_valid   <= issue_cell || issue_marker;
                rd_marker  <= issue_marker;
                vga_write  <= rd_valid;
                out_marker <= rd_marker;
            end
            if (vga_write && vga_ready && out_marker) begin
                active <= 1'b0;
                done   <= 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (issue_cell) begin
            rd_idx <= scan_idx;
        end
        if (advance && rd_valid) begin
            if (rd_marker) begin
                vga_x      <= `VGA_X_W'(player_cell_x);
                vga_y      <= `VGA_Y_W'(player_cell_y);
                vga_colour <= `COLOUR_PLAYER;
            end else begin
                vga_x      <= `VGA_X_W'(rd_idx[`CELL_X_W-1:0]);
                vga_y      <= `VGA_Y_W'(rd_idx[`CELL_X_W +: `CELL_Y_W]);
                vga_colour <= (grid.read_data == CELL_WALL) ? `COLOUR_WALL : `COLOUR_FLOOR;
            end
        end
    end
endmodule

//--- logic/player_updater.sv
`timescale 1ns/1ns
`include "maze_defines.svh"

module player_updater
    import maze_pkg::*;
(
    input  logic                 clock,
    input  logic                 reset,
    input  logic                 start,
    output logic                 done,
    input  logic                 turn_right,
    input  logic                 turn_left,
    input  logic                 move_forward,
    input  logic                 move_backward,
    grid_port_if.client          grid,
    output logic [`POS_X_W-1:0]  pos_x,
    output logic [`POS_Y_W-1:0]  pos_y,
    output logic [`ANGLE_W-1:0]  angle,
    output logic [`CELL_X_W-1:0] player_cell_x,
    output logic [`CELL_Y_W-1:0] player_cell_y
);
    localparam logic [`POS_X_W-1:0] START_X = `START_POS;
    localparam logic [`POS_Y_W-1:0] START_Y = `START_POS;
    localparam logic [`POS_X_W-1:0] STEP_X  = `MOVE_STEP;
    localparam logic [`POS_Y_W-1:0] STEP_Y  = `MOVE_STEP;
    localparam logic [`ANGLE_W-1:0] TURN    = `TURN_STEP;

    logic [1:0]          heading;
    logic [`POS_X_W-1:0] next_x;
    logic [`POS_X_W-1:0] target_x;
    logic [`POS_Y_W-1:0] next_y;
    logic [`POS_Y_W-1:0] target_y;
    logic [`ANGLE_W-1:0] next_angle;
    logic [`ANGLE_W-1:0] target_angle;
    logic                addr_phase;
    logic                check_phase;

    // Backward is forward on the opposite heading
    assign heading = angle[`ANGLE_W-1 -: 2] + {move_backward, 1'b0};

    always_comb begin
        next_x     = pos_x;
        next_y     = pos_y;
        next_angle = angle;
        if (move_forward ^ move_backward) begin
            case (heading)
                2'd0: next_x = pos_x + STEP_X;
                2'd1: next_y = pos_y + STEP_Y;
                2'd2: next_x = pos_x - STEP_X;
                default: next_y = pos_y - STEP_Y;
            endcase
        end
        if (turn_right && !turn_left) begin
            next_angle = angle + TURN;
        end else if (turn_left && !turn_right) begin
            next_angle = angle - TURN;
        end
    end

    always_ff @(posedge clock) begin
        if (start) begin
            target_x     <= next_x;
            target_y     <= next_y;
            target_angle <= next_angle;
        end
    end

    assign grid.cell_x     = target_x[`FRAC_W +: `CELL_X_W];
    assign grid.cell_y     = target_y[`FRAC_W +: `CELL_Y_W];
    assign grid.write      = 1'b0;
    assign grid.write_data = '0;

    always_ff @(posedge clock) begin
        if (reset) begin
            addr_phase  <= 1'b0;
            check_phase <= 1'b0;
            done        <= 1'b0;
            pos_x       <= START_X;
            pos_y       <= START_Y;
            angle       <= '0;
        end else begin
            addr_phase  <= start;
            check_phase <= addr_phase;
            done        <= check_phase;
            if (check_phase) begin
                angle <= target_angle;
                // Blocked by a wall
                if (grid.read_data != CELL_WALL) begin
                    pos_x <= target_x;
                    pos_y <= target_y;
                end
            end
        end
    end

    assign player_cell_x = pos_x[`FRAC_W +: `CELL_X_W];
    assign player_cell_y = pos_y[`FRAC_W +: `CELL_Y_W];
endmodule

//--- logic/maze_top.sv
`timescale 1ns/1ns
`include "maze_defines.svh"

module maze_top
    import maze_pkg::*;
(
    input  logic                 clock,
    input  logic                 reset,
    input  logic                 turn_right,
    input  logic                 turn_left,
    input  logic                 move_forward,
    input  logic                 move_backward,
    input  logic                 vga_ready,
    output logic [`VGA_X_W-1:0]  vga_x,
    output logic [`VGA_Y_W-1:0]  vga_y,
    output logic [`COLOUR_W-1:0] vga_colour,
    output logic                 vga_write,
    output logic [6:0]           hex0,
    output logic [6:0]           hex1,
    output logic [6:0]           hex4,
    output logic [6:0]           hex5,
    output logic [6:0]           hex6,
    output logic [6:0]           hex7
);
    logic                 load_start;
    logic                 load_done;
    logic                 render_start;
    logic                 render_done;
    logic                 update_start;
    logic                 update_done;
    grid_owner_t          grid_owner;
    logic [`POS_X_W-1:0]  pos_x;
    logic [`POS_Y_W-1:0]  pos_y;
    logic [`ANGLE_W-1:0]  angle;
    logic [`CELL_X_W-1:0] player_cell_x;
    logic [`CELL_Y_W-1:0] player_cell_y;
    logic [23:0]          hex_digits;
    logic [6:0]           segments [6];

    grid_port_if loader_port ();
    grid_port_if renderer_port ();
    grid_port_if updater_port ();

    game_sequencer u_sequencer (
        .clock(clock), .reset(reset),
        .load_done(load_done), .render_done(render_done), .update_done(update_done),
        .load_start(load_start), .render_start(render_start), .update_start(update_start),
        .grid_owner(grid_owner)
    );

    grid_memory u_grid (
        .clock(clock), .grid_owner(grid_owner),
        .loader(loader_port), .renderer(renderer_port), .updater(updater_port)
    );

    level_loader u_loader (
        .clock(clock), .reset(reset), .start(load_start), .done(load_done),
        .grid(loader_port)
    );

    grid_renderer u_renderer (
        .clock(clock), .reset(reset), .start(render_start), .done(render_done),
        .grid(renderer_port),
        .player_cell_x(player_cell_x), .player_cell_y(player_cell_y),
        .vga_ready(vga_ready), .vga_x(vga_x), .vga_y(vga_y),
        .vga_colour(vga_colour), .vga_write(vga_write)
    );

    player_updater u_player (
        .clock(clock), .reset(reset), .start(update_start), .done(update_done),
        .turn_right(turn_right), .turn_left(turn_left),
        .move_forward(move_forward), .move_backward(move_backward),
        .grid(updater_port),
        .pos_x(pos_x), .pos_y(pos_y), .angle(angle),
        .player_cell_x(player_cell_x), .player_cell_y(player_cell_y)
    );

    // Low bytes of X, Y and angle, most significant display first
    assign hex_digits = {pos_x[7:0], pos_y[7:0], angle};

    for (genvar i = 0; i < 6; i++) begin : g_hex
        hex_decoder u_hex (
            .nibble(hex_digits[4*i +: 4]),
            .segments(segments[i])
        );
    end

    assign hex0 = segments[0];
    assign hex1 = segments[1];
    assign hex4 = segments[2];
    assign hex5 = segments[3];
    assign hex6 = segments[4];
    assign hex7 = segments[5];
endmodule

//--- dv/clock_gen.sv
`timescale 1ns/1ns

module clock_gen #(
    parameter int PERIOD_NS    = 20,
    parameter int RESET_CYCLES = 10
) (
    output logic clock,
    output logic reset
);
    initial begin
        clock = 1'b0;
        forever #(PERIOD_NS / 2) clock = ~clock;
    end

    // Release on a falling edge, away from the sampling edge
    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
    end
endmodule

//--- dv/maze_tb.sv
`timescale 1ns/1ns
`include "maze_defines.svh"

module maze_tb;
    localparam int     FRAMES          = 12;
    localparam int     CELLS           = `GRID_W * `GRID_H;
    localparam int     PIXELS          = CELLS + 1;
    localparam int     PERIOD_NS       = 20;
    localparam longint WATCHDOG_CYCLES = CELLS + FRAMES * PIXELS * 4 + 1000;

    logic                 clock;
    logic                 reset;
    logic                 turn_right;
    logic                 turn_left;
    logic                 move_forward;
    logic                 move_backward;
    logic                 vga_ready;
    logic [`VGA_X_W-1:0]  vga_x;
    logic [`VGA_Y_W-1:0]  vga_y;
    logic [`COLOUR_W-1:0] vga_colour;
    logic                 vga_write;
    logic [6:0]           hex0;
    logic [6:0]           hex1;
    logic [6:0]           hex4;
    logic [6:0]           hex5;
    logic [6:0]           hex6;
    logic [6:0]           hex7;

    // Reference player state
    logic [`POS_X_W-1:0]  model_x;
    logic [`POS_Y_W-1:0]  model_y;
    logic [`ANGLE_W-1:0]  model_angle;

    int errors;
    int tests_run;
    int tests_failed;

    clock_gen #(.PERIOD_NS(PERIOD_NS), .RESET_CYCLES(10)) clocks (
        .clock(clock),
        .reset(reset)
    );

    maze_top dut (
        .clock(clock), .reset(reset),
        .turn_right(turn_right), .turn_left(turn_left),
        .move_forward(move_forward), .move_backward(move_backward),
        .vga_ready(vga_ready), .vga_x(vga_x), .vga_y(vga_y),
        .vga_colour(vga_colour), .vga_write(vga_write),
        .hex0(hex0), .hex1(hex1), .hex4(hex4), .hex5(hex5), .hex6(hex6), .hex7(hex7)
    );

    function automatic logic is_wall(input int x, input int y);
        logic border;
        logic pillar;
        border = (x == 0) || (x == `GRID_W - 1) || (y == 0) || (y == `GRID_H - 1);
        pillar = (x % `PILLAR_PERIOD == `PILLAR_PHASE) && (y % `PILLAR_PERIOD == `PILLAR_PHASE);
        return border || pillar;
    endfunction

    // Active low, segment a in bit 0
    function automatic logic [6:0] seg_pattern(input logic [3:0] digit);
        case (digit)
            4'h0: return 7'h40;
            4'h1: return 7'h79;
            4'h2: return 7'h24;
            4'h3: return 7'h30;
            4'h4: return 7'h19;
            4'h5: return 7'h12;
            4'h6: return 7'h02;
            4'h7: return 7'h78;
            4'h8: return 7'h00;
            4'h9: return 7'h10;
            4'ha: return 7'h08;
            4'hb: return 7'h03;
            4'hc: return 7'h46;
            4'hd: return 7'h21;
            4'he: return 7'h06;
            default: return 7'h0e;
        endcase
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        assert (got === expected) else begin
            $display("mismatch %s: got %h expected %h", name, got, expected);
            errors++;
        end
    endtask

    task automatic check_displays();
        check_value("hex7", 32'(hex7), 32'(seg_pattern(model_x[7:4])));
        check_value("hex6", 32'(hex6), 32'(seg_pattern(model_x[3:0])));
        check_value("hex5", 32'(hex5), 32'(seg_pattern(model_y[7:4])));
        check_value("hex4", 32'(hex4), 32'(seg_pattern(model_y[3:0])));
        check_value("hex1", 32'(hex1), 32'(seg_pattern(model_angle[7:4])));
        check_value("hex0", 32'(hex0), 32'(seg_pattern(model_angle[3:0])));
    endtask

    task automatic apply_update();
        logic [1:0]          heading;
        logic [`POS_X_W-1:0] target_x;
        logic [`POS_Y_W-1:0] target_y;
        heading  = model_angle[`ANGLE_W-1 -: 2];
        target_x = model_x;
        target_y = model_y;
        if (move_forward != move_backward) begin
            if (move_backward) begin
                heading = heading + 2'd2;
            end
            case (heading)
                2'd0: target_x = model_x + `POS_X_W'(`MOVE_STEP);
                2'd1: target_y = model_y + `POS_Y_W'(`MOVE_STEP);
                2'd2: target_x = model_x - `POS_X_W'(`MOVE_STEP);
                default: target_y = model_y - `POS_Y_W'(`MOVE_STEP);
            endcase
        end
        if (!is_wall(int'(target_x[`FRAC_W +: `CELL_X_W]), int'(target_y[`FRAC_W +: `CELL_Y_W])))
        begin
            model_x = target_x;
            model_y = target_y;
        end
        if (turn_right && !turn_left) begin
            model_angle = model_angle + `ANGLE_W'(`TURN_STEP);
        end else if (turn_left && !turn_right) begin
            model_angle = model_angle - `ANGLE_W'(`TURN_STEP);
        end
    endtask

    task automatic finish_test(input string name, input int start_errors);
        tests_run++;
        if (errors != start_errors) begin
            tests_failed++;
        end
        $display("%s: %0d errors", name, errors - start_errors);
    endtask

    task automatic check_reset();
        int start_errors;
        start_errors = errors;
        check_value("vga_write", 32'(vga_write), 32'd0);
        check_displays();
        finish_test("reset", start_errors);
    endtask

    task automatic run_frame(input int frame);
        int                   accepted;
        int                   start_errors;
        int                   exp_x;
        int                   exp_y;
        int                   exp_colour;
        logic                 pending;
        logic                 controls_due;
        logic [`VGA_X_W-1:0]  held_x;
        logic [`VGA_Y_W-1:0]  held_y;
        logic [`COLOUR_W-1:0] held_colour;
        accepted     = 0;
        start_errors = errors;
        pending      = 1'b0;
        controls_due = 1'b0;
        while (accepted < PIXELS) begin
            @(negedge clock);
            if (controls_due) begin
                {turn_right, turn_left, move_forward, move_backward} = 4'($urandom_range(15, 0));
                controls_due = 1'b0;
            end
            // Stalled pixel must not move
            if (pending) begin
                check_value("vga_write held", 32'(vga_write), 32'd1);
                check_value("vga_x held", 32'(vga_x), 32'(held_x));
                check_value("vga_y held", 32'(vga_y), 32'(held_y));
                check_value("vga_colour held", 32'(vga_colour), 32'(held_colour));
            end
            vga_ready = ($urandom_range(9, 0) < 6);
            pending   = vga_write && !vga_ready;
            held_x      = vga_x;
            held_y      = vga_y;
            held_colour = vga_colour;
            if (vga_write && vga_ready) begin
                if (accepted == 0) begin
                    controls_due = 1'b1;
                    if (frame > 0) begin
                        check_displays();
                    end
                end
                if (accepted < CELLS) begin
                    exp_x      = accepted % `GRID_W;
                    exp_y      = accepted / `GRID_W;
                    exp_colour = is_wall(exp_x, exp_y) ? `COLOUR_WALL : `COLOUR_FLOOR;
                end else begin
                    exp_x      = int'(model_x[`FRAC_W +: `CELL_X_W]);
                    exp_y      = int'(model_y[`FRAC_W +: `CELL_Y_W]);
                    exp_colour = `COLOUR_PLAYER;
                end
                check_value("vga_x", 32'(vga_x), 32'(exp_x));
                check_value("vga_y", 32'(vga_y), 32'(exp_y));
                check_value("vga_colour", 32'(vga_colour), 32'(exp_colour));
                accepted++;
            end
        end
        // Marker taken, the DUT now runs its update
        apply_update();
        finish_test($sformatf("frame %0d, %0d pixels", frame, accepted), start_errors);
    endtask

    // The last update shows up at the first pixel of the following frame
    task automatic check_last_update();
        int start_errors;
        start_errors = errors;
        do begin
            @(negedge clock);
            vga_ready = ($urandom_range(9, 0) < 6);
        end while (!(vga_write && vga_ready));
        check_displays();
        finish_test("final update", start_errors);
    endtask

    initial begin
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        void'($urandom(32'h3b21fced));
        turn_right    = 1'b0;
        turn_left     = 1'b0;
        move_forward  = 1'b0;
        move_backward = 1'b0;
        vga_ready     = 1'b0;
        model_x       = `POS_X_W'(`START_POS);
        model_y       = `POS_Y_W'(`START_POS);
        model_angle   = '0;
        @(negedge clock);
        while (reset) begin
            @(negedge clock);
        end
        check_reset();
        for (int frame = 0; frame < FRAMES; frame++) begin
            run_frame(frame);
        end
        check_last_update();
        $display("%0d tests, %0d passed, %0d failed, %0d errors",
                 tests_run, tests_run - tests_failed, tests_failed, errors);
        if (tests_failed == 0 && errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    // Four cycles per pixel is far beyond the worst back-pressure
    initial begin
        #(WATCHDOG_CYCLES * PERIOD_NS);
        $display("timeout: frames did not complete within %0d cycles", WATCHDOG_CYCLES);
        $display("Something failed");
        $finish;
    end
endmodule

//--- maze_top.f
+incdir+include
logic/maze_pkg.sv
logic/grid_port_if.sv
logic/hex_decoder.sv
logic/game_sequencer.sv
logic/grid_memory.sv
logic/level_loader.sv
logic/grid_renderer.sv
logic/player_updater.sv
logic/maze_top.sv
dv/clock_gen.sv
dv/maze_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= maze_tb
FILELIST  ?= maze_top.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= Everything OK

SIM     := $(BUILD_DIR)/V$(TOP)
SOURCES := $(wildcard logic/*.sv dv/*.sv include/*.svh)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   list these targets"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS PASS_TEXT"

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

test: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
